// ==== bench/obj_tb.sv ====
/*
 * sprite renderer testbench, attribute RAM and graphics port models
 * renders table cases and checks each line against a reference
 */
`timescale 1ns/1ns

module obj_tb;
    import obj_pkg::*;

    localparam int NUM_SPRITES = 16;
    localparam int LINE_W      = 64;
    localparam int NUM_CASES   = 7;
    localparam int N_ROWS      = 16;
    localparam int CYCLE_LIMIT = 2000 * NUM_CASES + 200;   // plus reset and sweep

    typedef struct packed {
        logic [3:0]  set_id;   // sprite set this row belongs to
        logic [3:0]  slot;
        logic        active;
        logic        flip;
        logic [3:0]  prio;
        logic [5:0]  pal;
        logic [14:0] code;
        logic [8:0]  x;
        logic [3:0]  w;        // tiles minus one
        logic [8:0]  y;
        logic [3:0]  h;
    } spr_row_t;

    typedef struct packed {
        logic [3:0] set_id;
        logic [8:0] line;
        logic       rnd;       // random ready delays
    } case_t;

    localparam spr_row_t SPR_ROWS [N_ROWS] = '{
        '{1, 0, 1, 0, 2, 1, 'h011, 4, 0, 20, 0},
        '{1, 1, 1, 0, 2, 2, 'h022, 16, 0, 28, 1},
        '{1, 2, 0, 0, 3, 3, 'h033, 30, 0, 8, 3},
        '{1, 5, 1, 0, 6, 4, 'h045, 40, 1, 10, 1},
        '{1, 7, 1, 0, 4, 5, 'h057, 24, 0, 25, 0},
        '{1, 15, 1, 1, 15, 63, 'h7ff, 50, 0, 12, 0},
        '{2, 0, 1, 0, 5, 3, 'h103, 10, 1, 0, 3},
        '{2, 1, 1, 0, 3, 4, 'h0f1, 14, 0, 0, 3},
        '{2, 2, 1, 0, 5, 5, 'h108, 18, 0, 0, 3},
        '{2, 3, 1, 0, 9, 6, 'h20c, 58, 1, 0, 3},
        '{2, 4, 1, 0, 0, 7, 'h000, 0, 3, 0, 3},
        '{3, 0, 1, 1, 1, 8, 'h2a5, 2, 2, 33, 0},
        '{3, 1, 1, 0, 1, 9, 'h2a5, 30, 2, 33, 0},
        '{3, 3, 1, 0, 0, 10, 'h013, 0, 3, 40, 0},
        '{3, 4, 1, 1, 0, 11, 'h1f6, 50, 1, 0, 15},
        '{3, 6, 1, 1, 2, 12, 'h3c0, 60, 0, 40, 0}
    };

    localparam case_t CASES [NUM_CASES] = '{
        '{0, 10, 0}, '{1, 24, 1}, '{1, 12, 1}, '{2, 7, 0},
        '{2, 7, 1}, '{3, 40, 1}, '{3, 40, 0}
    };

    logic                           CLK96;
    logic                           RESET96;
    logic                           line_start_i;
    logic [8:0]                     vrender_i;
    logic [$clog2(NUM_SPRITES)+1:0] attr_addr_o;
    logic [15:0]                    attr_data_i;
    logic                           gfx_cs_o;
    gfx_req_t                       gfx_req_o;
    logic                           gfx_ok_i;
    logic [31:0]                    gfx_data_i;
    logic                           pixel_cen_i;
    logic [8:0]                     h_i;
    obj_pixel_t                     obj_pixel_o;
    logic                           render_busy_o;

    logic [15:0]                    attr_mem [4*NUM_SPRITES];
    logic [$clog2(NUM_SPRITES)+1:0] attr_addr_q;
    obj_pixel_t                     exp_line [LINE_W];
    logic [31:0]                    lfsr_q;
    logic                           rand_delay;
    logic                           fetch_busy;
    gfx_req_t                       held_req;
    int                             wait_left;
    int                             pixel_errs;
    int                             other_errs;
    int                             cycles;

    obj_top #(
        .NUM_SPRITES (NUM_SPRITES),
        .LINE_W      (LINE_W)
    ) i_obj_top (
        .CLK96         (CLK96),
        .RESET96       (RESET96),
        .line_start_i  (line_start_i),
        .vrender_i     (vrender_i),
        .attr_addr_o   (attr_addr_o),
        .attr_data_i   (attr_data_i),
        .gfx_cs_o      (gfx_cs_o),
        .gfx_req_o     (gfx_req_o),
        .gfx_ok_i      (gfx_ok_i),
        .gfx_data_i    (gfx_data_i),
        .pixel_cen_i   (pixel_cen_i),
        .h_i           (h_i),
        .obj_pixel_o   (obj_pixel_o),
        .render_busy_o (render_busy_o)
    );

    initial begin
        CLK96 = 1'b0;
        forever #20 CLK96 = ~CLK96;
    end

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic rand_bit();
        logic out;
        out    = lfsr_q[0];
        lfsr_q = {1'b0, lfsr_q[31:1]} ^ (out ? 32'h8020_0003 : 32'h0);
        return out;
    endfunction

    // one pixel of a tile slice
    function automatic logic [3:0] slice_px(input int code, input int col, input int row,
                                            input int k);
        return 4'(code + col + row + k);
    endfunction

    // attribute RAM, data one cycle after the address
    initial begin
        attr_data_i = '0;
        attr_addr_q = '0;
        forever begin
            @(posedge CLK96);
            #2;
            attr_data_i = attr_mem[attr_addr_q];
            attr_addr_q = attr_addr_o;
        end
    end

    // graphics port, ready after 0 to 3 cycles
    initial begin
        gfx_ok_i   = 1'b0;
        gfx_data_i = '0;
        lfsr_q     = 32'hd3ee;
        fetch_busy = 1'b0;
        wait_left  = 0;
        forever begin
            @(posedge CLK96);
            #2;
            if (gfx_ok_i) begin
                gfx_ok_i = 1'b0;
                if (gfx_cs_o) begin
                    other_errs++;
                    $display("graphics chip select still high after the ready cycle");
                end
            end else if (gfx_cs_o) begin
                if (!fetch_busy) begin
                    fetch_busy = 1'b1;
                    held_req   = gfx_req_o;
                    wait_left  = 0;
                    if (rand_delay) begin
                        wait_left = 2 * int'(rand_bit());
                        wait_left = wait_left + int'(rand_bit());
                    end
                end
                if (gfx_req_o !== held_req) begin
                    other_errs++;
                    $display("Error: gfx_req_o is %h, expected %h", gfx_req_o, held_req);
                end
                if (wait_left == 0) begin
                    gfx_ok_i   = 1'b1;
                    fetch_busy = 1'b0;
                    for (int k = 0; k < 8; k++) begin
                        gfx_data_i[4*k +: 4] = slice_px(int'(gfx_req_o.code),
                            int'(gfx_req_o.col), int'(gfx_req_o.row), k);
                    end
                end else begin
                    wait_left--;
                end
            end else if (fetch_busy) begin
                other_errs++;
                fetch_busy = 1'b0;
                $display("graphics chip select dropped before the ready cycle");
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge CLK96);
            cycles++;
        end
        other_errs++;
        $display("timeout after %0d cycles, a render or readout never finished", cycles);
        $display("errors: %0d pixel, %0d other", pixel_errs, other_errs);
        $display("Test FAILED");
        $finish;
    end

    task automatic load_set(input int set_sel);
        spr_row_t r;
        int       s;
        for (int a = 0; a < 4*NUM_SPRITES; a++) begin
            attr_mem[a] = '0;
        end
        for (int i = 0; i < N_ROWS; i++) begin
            r = SPR_ROWS[i];
            s = int'(r.slot);
            if (int'(r.set_id) == set_sel) begin
                attr_mem[4*s]     = {r.active, 2'b00, r.flip, r.prio, 2'b00, r.pal};
                attr_mem[4*s + 1] = {1'b0, r.code};
                attr_mem[4*s + 2] = {r.x, 3'b000, r.w};
                attr_mem[4*s + 3] = {r.y, 3'b000, r.h};
            end
        end
    endtask

    // expected line straight from the attribute words
    task automatic build_expected(input int line);
        int         flp;
        int         pri;
        int         x;
        int         w;
        int         h;
        int         dy;
        int         pos;
        int         scol;
        logic [3:0] clr;
        for (int i = 0; i < LINE_W; i++) begin
            exp_line[i] = '0;
        end
        for (int p = 0; p < 16; p++) begin
            for (int s = 0; s < NUM_SPRITES; s++) begin
                pri = int'(attr_mem[4*s][11:8]);
                flp = int'(attr_mem[4*s][12]);
                x   = int'(attr_mem[4*s + 2][15:7]);
                w   = int'(attr_mem[4*s + 2][3:0]);
                h   = int'(attr_mem[4*s + 3][3:0]);
                dy  = line - int'(attr_mem[4*s + 3][15:7]);
                if (attr_mem[4*s][15] && pri == p && dy >= 0 && dy < 8 * (h + 1)) begin
                    for (int c = 0; c <= w; c++) begin
                        for (int k = 0; k < 8; k++) begin
                            clr  = slice_px(int'(attr_mem[4*s + 1][3:0]), c, dy, k);
                            scol = (flp == 1) ? w - c : c;
                            pos  = x + 8 * scol + ((flp == 1) ? 7 - k : k);
                            if (clr != 4'd0 && pos < LINE_W) begin
                                exp_line[pos].prio    = 4'(pri);
                                exp_line[pos].palette = attr_mem[4*s][5:0];
                                exp_line[pos].colour  = clr;
                            end
                        end
                    end
                end
            end
        end
    endtask

    task automatic start_line(input logic [8:0] line);
        @(posedge CLK96);
        #2;
        line_start_i = 1'b1;
        vrender_i    = line;
        @(posedge CLK96);
        #2;
        line_start_i = 1'b0;
        if (render_busy_o !== 1'b1) begin
            other_errs++;
            $display("Error: render_busy_o is %h after line start, expected 1", render_busy_o);
        end
        while (render_busy_o) begin
            @(posedge CLK96);
            #2;
        end
    endtask

    // walks h past the line end, the last two reads are out of range
    task automatic read_line(input logic drawn);
        obj_pixel_t want;
        for (int i = 0; i <= LINE_W + 2; i++) begin
            @(posedge CLK96);
            #2;
            if (i > 0) begin
                want = (drawn && i - 1 < LINE_W) ? exp_line[i - 1] : '0;
                if (obj_pixel_o !== want) begin
                    pixel_errs++;
                    $display("Error: obj_pixel_o at h %0d is %h, expected %h",
                             i - 1, obj_pixel_o, want);
                end
            end
            pixel_cen_i = (i < LINE_W + 2);
            h_i         = 9'(i);
        end
        pixel_cen_i = 1'b0;
    endtask

    initial begin
        RESET96      = 1'b1;
        line_start_i = 1'b0;
        vrender_i    = '0;
        pixel_cen_i  = 1'b0;
        h_i          = '0;
        rand_delay   = 1'b0;
        pixel_errs   = 0;
        other_errs   = 0;
        load_set(0);
        repeat (16) @(posedge CLK96);
        #2;
        RESET96 = 1'b0;
        if (render_busy_o !== 1'b0 || gfx_cs_o !== 1'b0 || obj_pixel_o !== '0) begin
            other_errs++;
            $display("Error: render_busy_o %h gfx_cs_o %h obj_pixel_o %h after reset, expected 0",
                     render_busy_o, gfx_cs_o, obj_pixel_o);
        end
        repeat (LINE_W + 4) @(posedge CLK96);   // power-up sweep of both halves
        for (int c = 0; c < NUM_CASES; c++) begin
            load_set(int'(CASES[c].set_id));
            rand_delay = CASES[c].rnd;
            build_expected(int'(CASES[c].line));
            start_line(CASES[c].line);
            load_set(0);                        // next line stays empty
            start_line(9'd0);
            read_line(1'b1);
            read_line(1'b0);                    // erased by the first readout
        end
        $display("errors: %0d pixel, %0d other", pixel_errs, other_errs);
        if (pixel_errs == 0 && other_errs == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
hw/obj_pkg.sv
hw/obj_ram.sv
hw/obj_scan.sv
hw/obj_draw.sv
hw/obj_linebuf.sv
hw/obj_top.sv
bench/obj_tb.sv

// ==== hw/obj_draw.sv ====
/*
 * sprite drawer, walks the priority queues lowest first
 * and paints fetched tile slices into the back line half
 */
`timescale 1ns/1ns

module obj_draw #(
    parameter int NUM_SPRITES = 256,
    parameter int LINE_W      = 320
) (
    input  logic                                               CLK96,
    input  logic                                               RESET96,
    input  logic                                               line_start_i,
    input  logic                                               scan_done_i,
    input  obj_pkg::queue_counts_t                             counts_i,
    output logic [$clog2(obj_pkg::PRI_LEVELS*NUM_SPRITES)-1:0] q_rd_addr_o,
    input  obj_pkg::sprite_entry_t                             q_rd_data_i,
    output logic                                               gfx_cs_o,
    output obj_pkg::gfx_req_t                                  gfx_req_o,
    input  logic                                               gfx_ok_i,
    input  logic [obj_pkg::GFX_W-1:0]                          gfx_data_i,
    output logic                                               px_we_o,
    output logic [$clog2(LINE_W)-1:0]                          px_addr_o,
    output obj_pkg::obj_pixel_t                                px_data_o,
    output logic                                               busy_o
);
    import obj_pkg::*;

    localparam int QAW = $clog2(PRI_LEVELS*NUM_SPRITES);
    localparam int AW  = $clog2(LINE_W);

    typedef enum logic [2:0] {D_IDLE, D_LEVEL, D_QREAD, D_LOAD, D_FETCH, D_PIX} state_t;

    state_t             state_q;
    logic [PRI_W:0]     lvl_from_q;   // search start, 16 means none left
    logic [PRI_W-1:0]   prio_q;
    logic [COUNT_W-1:0] idx_q;
    logic [SIZE_W-1:0]  t_q;          // tile column in fetch order
    logic [PX_W-1:0]    p_q;          // pixel within slice
    sprite_entry_t      entry_q;
    logic [GFX_W-1:0]   slice_q;
    logic               lvl_found;
    logic [PRI_W-1:0]   lvl_next;
    logic               idx_last;
    logic               last_px;
    logic [SIZE_W-1:0]  scol;
    logic [PX_W-1:0]    pix;
    logic [CLR_W-1:0]   colour;
    logic [POS_W:0]     xpos;

    // lowest non-empty level at or above lvl_from_q
    always_comb begin
        lvl_found = 1'b0;
        lvl_next  = '0;
        for (int p = PRI_LEVELS-1; p >= 0; p--) begin
            if (p >= int'(lvl_from_q) && counts_i[p] != '0) begin
                lvl_found = 1'b1;
                lvl_next  = PRI_W'(p);
            end
        end
    end

    assign q_rd_addr_o = QAW'(prio_q) * QAW'(NUM_SPRITES) + QAW'(idx_q);
    assign idx_last    = (COUNT_W'(idx_q + 1'b1) >= counts_i[prio_q]);
    assign last_px     = (p_q == PX_W'(TILE_PX-1));

    // flip reverses both tile columns and pixels
    assign scol   = entry_q.flip ? entry_q.width - t_q : t_q;
    assign pix    = entry_q.flip ? PX_W'(TILE_PX-1) - p_q : p_q;
    assign colour = slice_q[p_q*CLR_W +: CLR_W];
    assign xpos   = (POS_W+1)'(entry_q.x) + (POS_W+1)'({scol, {PX_W{1'b0}}})
                  + (POS_W+1)'(pix);

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            state_q    <= D_IDLE;
            busy_o     <= 1'b0;
            gfx_cs_o   <= 1'b0;
            px_we_o    <= 1'b0;
            lvl_from_q <= '0;
            prio_q     <= '0;
            idx_q      <= '0;
            t_q        <= '0;
            p_q        <= '0;
        end else begin
            px_we_o <= 1'b0;
            if (line_start_i) begin
                state_q  <= D_IDLE;     // drop whatever was in flight
                busy_o   <= 1'b1;
                gfx_cs_o <= 1'b0;
            end else begin
                case (state_q)
                    D_IDLE: begin
                        if (scan_done_i) begin
                            lvl_from_q <= '0;
                            state_q    <= D_LEVEL;
                        end
                    end
                    D_LEVEL: begin
                        if (lvl_found) begin
                            prio_q  <= lvl_next;
                            idx_q   <= '0;
                            state_q <= D_QREAD;
                        end else begin
                            busy_o  <= 1'b0;
                            state_q <= D_IDLE;
                        end
                    end
                    D_QREAD: state_q <= D_LOAD;   // queue data next cycle
                    D_LOAD: begin
                        t_q      <= '0;
                        gfx_cs_o <= 1'b1;
                        state_q  <= D_FETCH;
                    end
                    D_FETCH: begin
                        if (gfx_ok_i) begin
                            gfx_cs_o <= 1'b0;
                            p_q      <= '0;
                            state_q  <= D_PIX;
                        end
                    end
                    D_PIX: begin
                        px_we_o <= (colour != '0) && (xpos < (POS_W+1)'(LINE_W));
                        p_q     <= p_q + 1'b1;
                        if (last_px) begin
                            if (t_q != entry_q.width) begin
                                t_q      <= t_q + 1'b1;
                                gfx_cs_o <= 1'b1;
                                state_q  <= D_FETCH;
                            end else if (!idx_last) begin
                                idx_q   <= idx_q + 1'b1;
                                state_q <= D_QREAD;
                            end else begin
                                lvl_from_q <= {1'b0, prio_q} + 1'b1;
                                state_q    <= D_LEVEL;
                            end
                        end
                    end
                    default: state_q <= D_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge CLK96) begin
        if (state_q == D_LOAD) begin
            entry_q        <= q_rd_data_i;
            gfx_req_o.code <= q_rd_data_i.code;
            gfx_req_o.col  <= '0;
            gfx_req_o.row  <= q_rd_data_i.row;
        end
        if (state_q == D_PIX && last_px) begin
            gfx_req_o.col <= t_q + 1'b1;   // next column, ignored after the last one
        end
        if (state_q == D_FETCH && gfx_ok_i) begin
            slice_q <= gfx_data_i;
        end
        if (state_q == D_PIX) begin
            px_addr_o         <= xpos[AW-1:0];
            px_data_o.prio    <= prio_q;
            px_data_o.palette <= entry_q.palette;
            px_data_o.colour  <= colour;
        end
    end

endmodule

// ==== hw/obj_linebuf.sv ====
/*
 * double line buffer, back half drawn while front half reads out
 * front entries are erased after they are read
 */
`timescale 1ns/1ns

module obj_linebuf #(
    parameter int LINE_W = 320
) (
    input  logic                      CLK96,
    input  logic                      RESET96,
    input  logic                      line_start_i,
    input  logic                      px_we_i,
    input  logic [$clog2(LINE_W)-1:0] px_addr_i,
    input  obj_pkg::obj_pixel_t       px_data_i,
    input  logic                      pixel_cen_i,
    input  logic [obj_pkg::POS_W-1:0] h_i,
    output obj_pkg::obj_pixel_t       obj_pixel_o
);
    import obj_pkg::*;

    localparam int AW = $clog2(LINE_W);

    logic          front_q;       // half being read out
    logic          clr_q;         // power-up sweep
    logic [AW-1:0] clr_addr_q;
    logic          rd_ok;
    logic          rd_cen_q;
    logic          rd_ok_q;
    logic          rd_half_q;
    logic [AW-1:0] rd_addr_q;
    obj_pixel_t    hold_q;
    obj_pixel_t    rd_data [2];

    assign rd_ok = pixel_cen_i && (h_i < POS_W'(LINE_W)) && !clr_q;

    // out of range reads show zero, idle cycles keep the last pixel
    assign obj_pixel_o = rd_cen_q ? (rd_ok_q ? rd_data[rd_half_q] : '0) : hold_q;

    for (genvar i = 0; i < 2; i++) begin : g_half
        logic          erase;
        logic          we;
        logic [AW-1:0] wa;
        obj_pixel_t    wd;

        assign erase = rd_ok_q && (rd_half_q == 1'(i));
        assign we    = clr_q || erase || (px_we_i && (front_q != 1'(i)));
        assign wa    = clr_q ? clr_addr_q : (erase ? rd_addr_q : px_addr_i);
        assign wd    = (clr_q || erase) ? '0 : px_data_i;

        obj_ram #(
            .T     (obj_pixel_t),
            .DEPTH (LINE_W),
            .AW    (AW)
        ) i_ram (
            .CLK96     (CLK96),
            .wr_en_i   (we),
            .wr_addr_i (wa),
            .wr_data_i (wd),
            .rd_addr_i (h_i[AW-1:0]),
            .rd_data_o (rd_data[i])
        );
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            front_q    <= 1'b0;
            clr_q      <= 1'b1;
            clr_addr_q <= '0;
            rd_cen_q   <= 1'b0;
            rd_ok_q    <= 1'b0;
            rd_half_q  <= 1'b0;
            hold_q     <= '0;
        end else begin
            if (line_start_i) begin
                front_q <= !front_q;
            end
            if (clr_q) begin
                clr_addr_q <= clr_addr_q + 1'b1;
                if (clr_addr_q == AW'(LINE_W-1)) begin
                    clr_q <= 1'b0;
                end
            end
            rd_cen_q  <= pixel_cen_i;
            rd_ok_q   <= rd_ok;
            rd_half_q <= front_q;
            hold_q    <= obj_pixel_o;
        end
    end

    always_ff @(posedge CLK96) begin
        rd_addr_q <= h_i[AW-1:0];   // erase target
    end

endmodule

// ==== hw/obj_pkg.sv ====
/*
 * sprite renderer shared definitions
 * attribute word layout, queue entry, buffered pixel and fetch request
 */
package obj_pkg;

    localparam int PRI_LEVELS = 16;
    localparam int COUNT_W    = 9;               // per-priority sprite count
    localparam int TILE_PX    = 8;               // pixels per tile slice
    localparam int PX_W       = $clog2(TILE_PX);
    localparam int POS_W      = 9;               // screen x and y
    localparam int ATTR_W     = 16;

    localparam int PRI_W  = 4;
    localparam int PAL_W  = 6;
    localparam int CLR_W  = 4;
    localparam int CODE_W = 15;
    localparam int SIZE_W = 4;
    localparam int ROW_W  = 7;
    localparam int GFX_W  = TILE_PX * CLR_W;     // one slice, pixel 0 lowest

    // word 0
    localparam int A0_ACTIVE  = 15;
    localparam int A0_FLIP    = 12;
    localparam int A0_PRI_LSB = 8;
    localparam int A0_PAL_LSB = 0;
    // word 1
    localparam int A1_CODE_LSB = 0;
    // words 2 and 3, position over size
    localparam int A23_POS_LSB  = 7;
    localparam int A23_SIZE_LSB = 0;

    typedef struct packed {
        logic [CODE_W-1:0] code;
        logic [POS_W-1:0]  x;
        logic [SIZE_W-1:0] width;    // tiles minus one
        logic [PAL_W-1:0]  palette;
        logic              flip;
        logic [ROW_W-1:0]  row;      // line within the sprite
    } sprite_entry_t;

    typedef struct packed {
        logic [PRI_W-1:0] prio;
        logic [PAL_W-1:0] palette;
        logic [CLR_W-1:0] colour;    // zero is empty
    } obj_pixel_t;

    typedef struct packed {
        logic [CODE_W-1:0] code;
        logic [SIZE_W-1:0] col;
        logic [ROW_W-1:0]  row;
    } gfx_req_t;

    typedef logic [PRI_LEVELS-1:0][COUNT_W-1:0] queue_counts_t;

endpackage

// ==== hw/obj_ram.sv ====
/*
 * simple dual-port RAM with registered read
 * payload type set per instance
 */
`timescale 1ns/1ns

module obj_ram #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 256,
    parameter int  AW    = 8
) (
    input  logic          CLK96,
    input  logic          wr_en_i,
    input  logic [AW-1:0] wr_addr_i,
    input  T              wr_data_i,
    input  logic [AW-1:0] rd_addr_i,
    output T              rd_data_o
);

    T mem [DEPTH];

    always_ff @(posedge CLK96) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
        rd_data_o <= mem[rd_addr_i];   // old data on a same-cycle write
    end

endmodule

// ==== hw/obj_scan.sv ====
/*
 * sprite scanner, walks the attribute table for one line
 * and queues every hit by priority
 */
`timescale 1ns/1ns

module obj_scan #(
    parameter int NUM_SPRITES = 256
) (
    input  logic                                               CLK96,
    input  logic                                               RESET96,
    input  logic                                               line_start_i,
    input  logic [obj_pkg::POS_W-1:0]                          vrender_i,
    output logic [$clog2(NUM_SPRITES)+1:0]                     attr_addr_o,
    input  logic [obj_pkg::ATTR_W-1:0]                         attr_data_i,
    output logic                                               q_wr_en_o,
    output logic [$clog2(obj_pkg::PRI_LEVELS*NUM_SPRITES)-1:0] q_wr_addr_o,
    output obj_pkg::sprite_entry_t                             q_wr_data_o,
    output logic                                               scan_done_o,
    output obj_pkg::queue_counts_t                             counts_o
);
    import obj_pkg::*;

    localparam int SW  = $clog2(NUM_SPRITES);
    localparam int QAW = $clog2(PRI_LEVELS*NUM_SPRITES);

    // named by the word address on the bus, data lags by one phase
    typedef enum logic [2:0] {P_IDLE, P_W0, P_W3, P_W1, P_W2, P_ENQ} phase_t;

    phase_t            phase_q;
    logic [SW-1:0]     spr_q;
    logic [1:0]        word;
    logic [POS_W:0]    dy;
    logic [SIZE_W-1:0] attr_size;
    logic [7:0]        span;
    logic              hit;
    logic              next_spr;
    logic              last_spr;
    logic [PRI_W-1:0]  prio_q;
    logic [PAL_W-1:0]  pal_q;
    logic              flip_q;
    logic [ROW_W-1:0]  row_q;
    logic [CODE_W-1:0] code_q;

    always_comb begin
        case (phase_q)
            P_W3:    word = 2'd3;
            P_W1:    word = 2'd1;
            P_W2:    word = 2'd2;
            default: word = 2'd0;
        endcase
    end

    assign attr_addr_o = {spr_q, word};

    // vertical hit test on word 3
    assign attr_size = attr_data_i[A23_SIZE_LSB +: SIZE_W];
    assign dy        = {1'b0, vrender_i} - {1'b0, attr_data_i[A23_POS_LSB +: POS_W]};
    assign span      = {(SIZE_W+1)'(attr_size) + (SIZE_W+1)'(1), 3'b000};
    assign hit       = !dy[POS_W] && (dy < (POS_W+1)'(span));

    assign last_spr = (spr_q == SW'(NUM_SPRITES-1));
    assign next_spr = (phase_q == P_W3 && !attr_data_i[A0_ACTIVE])
                   || (phase_q == P_W1 && !hit)
                   || (phase_q == P_ENQ);

    // entry completes with word 2
    assign q_wr_en_o   = (phase_q == P_ENQ);
    assign q_wr_addr_o = QAW'(prio_q) * QAW'(NUM_SPRITES) + QAW'(counts_o[prio_q]);

    always_comb begin
        q_wr_data_o.code    = code_q;
        q_wr_data_o.x       = attr_data_i[A23_POS_LSB +: POS_W];
        q_wr_data_o.width   = attr_data_i[A23_SIZE_LSB +: SIZE_W];
        q_wr_data_o.palette = pal_q;
        q_wr_data_o.flip    = flip_q;
        q_wr_data_o.row     = row_q;
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            phase_q     <= P_IDLE;
            spr_q       <= '0;
            counts_o    <= '0;
            scan_done_o <= 1'b0;
        end else begin
            scan_done_o <= 1'b0;
            if (line_start_i) begin
                phase_q  <= P_W0;
                spr_q    <= '0;
                counts_o <= '0;
            end else begin
                case (phase_q)
                    P_W0:    phase_q <= P_W3;
                    P_W3:    phase_q <= P_W1;
                    P_W1:    phase_q <= P_W2;
                    P_W2:    phase_q <= P_ENQ;
                    P_ENQ:   counts_o[prio_q] <= counts_o[prio_q] + 1'b1;
                    default: ;
                endcase
                if (next_spr) begin
                    if (last_spr) begin
                        phase_q     <= P_IDLE;
                        scan_done_o <= 1'b1;
                    end else begin
                        spr_q   <= spr_q + 1'b1;
                        phase_q <= P_W0;
                    end
                end
            end
        end
    end

    always_ff @(posedge CLK96) begin
        case (phase_q)
            P_W3: begin
                flip_q <= attr_data_i[A0_FLIP];
                prio_q <= attr_data_i[A0_PRI_LSB +: PRI_W];
                pal_q  <= attr_data_i[A0_PAL_LSB +: PAL_W];
            end
            P_W1:    row_q  <= dy[ROW_W-1:0];
            P_W2:    code_q <= attr_data_i[A1_CODE_LSB +: CODE_W];
            default: ;
        endcase
    end

endmodule

// ==== hw/obj_top.sv ====
/*
 * sprite renderer top, scanner and drawer around the priority queue
 * feeding a double line buffer
 */
`timescale 1ns/1ns

module obj_top #(
    parameter int NUM_SPRITES = 256,
    parameter int LINE_W      = 320
) (
    input  logic                           CLK96,
    input  logic                           RESET96,
    input  logic                           line_start_i,
    input  logic [obj_pkg::POS_W-1:0]      vrender_i,
    output logic [$clog2(NUM_SPRITES)+1:0] attr_addr_o,
    input  logic [obj_pkg::ATTR_W-1:0]     attr_data_i,
    output logic                           gfx_cs_o,
    output obj_pkg::gfx_req_t              gfx_req_o,
    input  logic                           gfx_ok_i,
    input  logic [obj_pkg::GFX_W-1:0]      gfx_data_i,
    input  logic                           pixel_cen_i,
    input  logic [obj_pkg::POS_W-1:0]      h_i,
    output obj_pkg::obj_pixel_t            obj_pixel_o,
    output logic                           render_busy_o
);
    import obj_pkg::*;

    localparam int QAW = $clog2(PRI_LEVELS*NUM_SPRITES);
    localparam int AW  = $clog2(LINE_W);

    logic           q_wr_en;
    logic [QAW-1:0] q_wr_addr;
    sprite_entry_t  q_wr_data;
    logic [QAW-1:0] q_rd_addr;
    sprite_entry_t  q_rd_data;
    logic           scan_done;
    queue_counts_t  counts;
    logic           px_we;
    logic [AW-1:0]  px_addr;
    obj_pixel_t     px_data;

    obj_scan #(
        .NUM_SPRITES (NUM_SPRITES)
    ) i_obj_scan (
        .CLK96        (CLK96),
        .RESET96      (RESET96),
        .line_start_i (line_start_i),
        .vrender_i    (vrender_i),
        .attr_addr_o  (attr_addr_o),
        .attr_data_i  (attr_data_i),
        .q_wr_en_o    (q_wr_en),
        .q_wr_addr_o  (q_wr_addr),
        .q_wr_data_o  (q_wr_data),
        .scan_done_o  (scan_done),
        .counts_o     (counts)
    );

    obj_ram #(
        .T     (sprite_entry_t),
        .DEPTH (PRI_LEVELS*NUM_SPRITES),
        .AW    (QAW)
    ) i_obj_queue (
        .CLK96     (CLK96),
        .wr_en_i   (q_wr_en),
        .wr_addr_i (q_wr_addr),
        .wr_data_i (q_wr_data),
        .rd_addr_i (q_rd_addr),
        .rd_data_o (q_rd_data)
    );

    obj_draw #(
        .NUM_SPRITES (NUM_SPRITES),
        .LINE_W      (LINE_W)
    ) i_obj_draw (
        .CLK96        (CLK96),
        .RESET96      (RESET96),
        .line_start_i (line_start_i),
        .scan_done_i  (scan_done),
        .counts_i     (counts),
        .q_rd_addr_o  (q_rd_addr),
        .q_rd_data_i  (q_rd_data),
        .gfx_cs_o     (gfx_cs_o),
        .gfx_req_o    (gfx_req_o),
        .gfx_ok_i     (gfx_ok_i),
        .gfx_data_i   (gfx_data_i),
        .px_we_o      (px_we),
        .px_addr_o    (px_addr),
        .px_data_o    (px_data),
        .busy_o       (render_busy_o)
    );

    obj_linebuf #(
        .LINE_W (LINE_W)
    ) i_obj_linebuf (
        .CLK96        (CLK96),
        .RESET96      (RESET96),
        .line_start_i (line_start_i),
        .px_we_i      (px_we),
        .px_addr_i    (px_addr),
        .px_data_i    (px_data),
        .pixel_cen_i  (pixel_cen_i),
        .h_i          (h_i),
        .obj_pixel_o  (obj_pixel_o)
    );

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f build.f --top-module obj_tb -o obj_tb_sim
out=$(./obj_dir/obj_tb_sim)
echo "$out"
if echo "$out" | grep -qx 'Test OK'; then
    exit 0
fi
exit 1
